//--- Bender.yml
package:
  name: fetch_backend

sources:
  - src/fetch_pkg.sv
  - src/fetch_pkt_if.sv
  - src/if1_stage_reg.sv
  - src/ibar_sync.sv
  - src/fetch_buffer.sv
  - src/fetch_backend.sv
  - target: test
    files:
      - tests/fetch_backend_props.sv
      - tests/fetch_backend_tb.sv

//--- src.f
src/fetch_pkg.sv
src/fetch_pkt_if.sv
src/if1_stage_reg.sv
src/ibar_sync.sv
src/fetch_buffer.sv
src/fetch_backend.sv
tests/fetch_backend_props.sv
tests/fetch_backend_tb.sv

//--- src/fetch_backend.sv
`timescale 1ns/10ps

module fetch_backend #(
    parameter int FB_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  fetch_pkg::pc_t        in_pc,
    input  fetch_pkg::inst_t      in_inst0,
    input  fetch_pkg::inst_t      in_inst1,
    input  logic                  in_excp_flag,
    input  fetch_pkg::excp_code_t in_excp_code,

    input  logic                  ex_ibar_done,  // barrier retired in execute
    input  logic                  icache_idle,
    input  logic                  dcache_idle,
    output logic                  refetch_valid,
    output fetch_pkg::pc_t        refetch_pc,

    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::pc_t        out_pc,
    output fetch_pkg::inst_t      out_inst0,
    output fetch_pkg::inst_t      out_inst1,
    output logic                  out_excp_flag,
    output fetch_pkg::excp_code_t out_excp_code
);

    fetch_pkt_if if1_pkt ();
    fetch_pkt_if stage_pkt ();

    logic pkt_keep;

    // first fetch stage side
    assign if1_pkt.valid     = in_valid;
    assign if1_pkt.pc        = in_pc;
    assign if1_pkt.inst0     = in_inst0;
    assign if1_pkt.inst1     = in_inst1;
    assign if1_pkt.excp_flag = in_excp_flag;
    assign if1_pkt.excp_code = in_excp_code;
    assign in_ready          = if1_pkt.ready;

    if1_stage_reg if1_stage_reg_inst (
        .clk   (clk),
        .rstn  (rstn),
        .flush (flush),
        .in    (if1_pkt.dst),
        .out   (stage_pkt.src)
    );

    ibar_sync ibar_sync_inst (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .pkt           (stage_pkt.mon),
        .ex_ibar_done  (ex_ibar_done),
        .icache_idle   (icache_idle),
        .dcache_idle   (dcache_idle),
        .pkt_keep      (pkt_keep),
        .refetch_valid (refetch_valid),
        .refetch_pc    (refetch_pc)
    );

    fetch_buffer #(
        .FB_DEPTH (FB_DEPTH)
    ) fetch_buffer_inst (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .in            (stage_pkt.dst),
        .pkt_keep      (pkt_keep),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_inst0     (out_inst0),
        .out_inst1     (out_inst1),
        .out_excp_flag (out_excp_flag),
        .out_excp_code (out_excp_code)
    );

endmodule

//--- src/fetch_buffer.sv
`timescale 1ns/10ps

module fetch_buffer #(
    parameter int FB_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    fetch_pkt_if.dst              in,
    input  logic                  pkt_keep,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::pc_t        out_pc,
    output fetch_pkg::inst_t      out_inst0,
    output fetch_pkg::inst_t      out_inst1,
    output logic                  out_excp_flag,
    output fetch_pkg::excp_code_t out_excp_code
);

    localparam int PTR_W = $clog2(FB_DEPTH);
    localparam int CNT_W = $clog2(FB_DEPTH + 1);

    // entry storage, one array per field
    fetch_pkg::pc_t        pc_mem    [0:FB_DEPTH-1];
    fetch_pkg::inst_t      inst0_mem [0:FB_DEPTH-1];
    fetch_pkg::inst_t      inst1_mem [0:FB_DEPTH-1];
    logic                  flag_mem  [0:FB_DEPTH-1];
    fetch_pkg::excp_code_t code_mem  [0:FB_DEPTH-1];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full     = count_q == CNT_W'(FB_DEPTH);
    assign in.ready = ~full;

    // dropped packets are consumed without a write
    assign push = in.valid & in.ready & pkt_keep;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of two
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]    <= in.pc;
            inst0_mem[wr_ptr_q] <= in.inst0;
            inst1_mem[wr_ptr_q] <= in.inst1;
            flag_mem[wr_ptr_q]  <= in.excp_flag;
            code_mem[wr_ptr_q]  <= in.excp_code;
        end
    end

    // head entry toward decode
    assign out_valid     = count_q != '0;
    assign out_pc        = pc_mem[rd_ptr_q];
    assign out_inst0     = inst0_mem[rd_ptr_q];
    assign out_inst1     = inst1_mem[rd_ptr_q];
    assign out_excp_flag = flag_mem[rd_ptr_q];
    assign out_excp_code = code_mem[rd_ptr_q];

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

    // widths of the fetch packet fields
    localparam int PC_W        = 32;
    localparam int INST_W      = 32;
    localparam int EXCP_CODE_W = 7;

    // opcode field that identifies ibar, top bits of the word
    localparam int OPC_W = 17;

    typedef logic [PC_W-1:0]        pc_t;
    typedef logic [INST_W-1:0]      inst_t;
    typedef logic [EXCP_CODE_W-1:0] excp_code_t;
    typedef logic [OPC_W-1:0]       opc_t;

    // boot address, also the idle value of every stored pc
    localparam pc_t PC_RESET = 32'h1c00_0000;

    localparam pc_t INST_BYTES = 32'd4; // one instruction slot

    // andi r0, r0, 0
    localparam inst_t INST_NOP = 32'h0340_0000;

    // ibar hint sits in bits [14:0], not compared
    localparam opc_t IBAR_OP = 17'h0_70e5;

endpackage

//--- src/fetch_pkt_if.sv
`timescale 1ns/10ps

// one fetch packet with valid/ready handshake
interface fetch_pkt_if;

    logic                   valid;
    logic                   ready;
    fetch_pkg::pc_t         pc;
    fetch_pkg::inst_t       inst0;
    fetch_pkg::inst_t       inst1;
    logic                   excp_flag;
    fetch_pkg::excp_code_t  excp_code;

    // producer side
    modport src (
        output valid, pc, inst0, inst1, excp_flag, excp_code,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid, pc, inst0, inst1, excp_flag, excp_code,
        output ready
    );

    // observer, e.g. the barrier tracker
    modport mon (
        input valid, ready, pc, inst0, inst1, excp_flag, excp_code
    );

endinterface

//--- src/ibar_sync.sv
`timescale 1ns/10ps

module ibar_sync (
    input  logic           clk,
    input  logic           rstn,
    input  logic           flush,
    fetch_pkt_if.mon       pkt,
    input  logic           ex_ibar_done,
    input  logic           icache_idle,
    input  logic           dcache_idle,
    output logic           pkt_keep,
    output logic           refetch_valid,
    output fetch_pkg::pc_t refetch_pc
);

    typedef enum logic [1:0] {
        IDLE            = 2'b00,
        WAIT_EX_IBAR    = 2'b01,
        WAIT_CACHE_IDLE = 2'b11,
        WAIT_FETCH      = 2'b10
    } ibar_state_e;

    ibar_state_e    state_q;
    ibar_state_e    state_d;
    fetch_pkg::pc_t after_ibar_pc_q; // first pc behind the barrier
    fetch_pkg::pc_t ibar_next_pc;
    logic           refetch_q;

    logic hit0;
    logic hit1;
    logic ibar_hit;
    logic ibar_pos;   // 1 when only inst1 is ibar
    logic xfer;
    logic pc_match;
    logic cache_idle;
    logic start_wait;

    assign hit0 = pkt.inst0[fetch_pkg::INST_W-1 -: fetch_pkg::OPC_W] == fetch_pkg::IBAR_OP;
    assign hit1 = pkt.inst1[fetch_pkg::INST_W-1 -: fetch_pkg::OPC_W] == fetch_pkg::IBAR_OP;

    // faulting packets carry no valid instructions
    assign ibar_hit = ~pkt.excp_flag & (hit0 | hit1);
    assign ibar_pos = ~hit0;

    assign ibar_next_pc = ibar_pos ? pkt.pc + (fetch_pkg::INST_BYTES << 1)
                                   : pkt.pc + fetch_pkg::INST_BYTES;

    assign xfer       = pkt.valid & pkt.ready;
    assign pc_match   = pkt.pc == after_ibar_pc_q;
    assign cache_idle = icache_idle & dcache_idle;

    always_comb begin
        case (state_q)
            IDLE:       pkt_keep = 1'b1;
            WAIT_FETCH: pkt_keep = pc_match; // only the refetched packet survives
            default:    pkt_keep = 1'b0;
        endcase
    end

    // any kept packet with ibar opens a new wait, the refetched one too
    assign start_wait = xfer & pkt_keep & ibar_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_wait) state_d = WAIT_EX_IBAR;
            end
            WAIT_EX_IBAR: begin
                if (ex_ibar_done) state_d = WAIT_CACHE_IDLE;
            end
            WAIT_CACHE_IDLE: begin
                if (cache_idle) state_d = WAIT_FETCH;
            end
            WAIT_FETCH: begin
                if (xfer && pc_match) begin
                    state_d = start_wait ? WAIT_EX_IBAR : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= IDLE;
            refetch_q <= 1'b0;
        end else if (flush) begin
            state_q   <= IDLE;
            refetch_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            refetch_q <= (state_q == WAIT_CACHE_IDLE) & cache_idle; // single pulse
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            after_ibar_pc_q <= fetch_pkg::PC_RESET;
        end else if (start_wait && !flush) begin
            after_ibar_pc_q <= ibar_next_pc;
        end
    end

    assign refetch_valid = refetch_q;
    assign refetch_pc    = after_ibar_pc_q;

endmodule

//--- src/if1_stage_reg.sv
`timescale 1ns/10ps

module if1_stage_reg (
    input  logic     clk,
    input  logic     rstn,
    input  logic     flush,
    fetch_pkt_if.dst in,
    fetch_pkt_if.src out
);

    logic                  run_q;   // set once out of reset
    logic                  valid_q;
    fetch_pkg::pc_t        pc_q;
    fetch_pkg::inst_t      inst0_q;
    fetch_pkg::inst_t      inst1_q;
    logic                  excp_flag_q;
    fetch_pkg::excp_code_t excp_code_q;
    logic                  load;

    // empty, or the held packet leaves this cycle
    assign in.ready = run_q & ~flush & (~valid_q | out.ready);
    assign load     = in.valid & in.ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q     <= 1'b0;
            pc_q        <= fetch_pkg::PC_RESET;
            inst0_q     <= fetch_pkg::INST_NOP;
            inst1_q     <= fetch_pkg::INST_NOP;
            excp_flag_q <= 1'b0;
            excp_code_q <= '0;
        end else if (flush) begin
            valid_q     <= 1'b0;
            pc_q        <= fetch_pkg::PC_RESET;
            inst0_q     <= fetch_pkg::INST_NOP;
            inst1_q     <= fetch_pkg::INST_NOP;
            excp_flag_q <= 1'b0;
            excp_code_q <= '0;
        end else if (load) begin
            valid_q     <= 1'b1;
            pc_q        <= in.pc;
            inst0_q     <= in.inst0;
            inst1_q     <= in.inst1;
            excp_flag_q <= in.excp_flag;
            excp_code_q <= in.excp_code;
        end else if (out.ready) begin
            valid_q <= 1'b0; // drained, fields keep last value
        end
    end

    assign out.valid     = valid_q;
    assign out.pc        = pc_q;
    assign out.inst0     = inst0_q;
    assign out.inst1     = inst1_q;
    assign out.excp_flag = excp_flag_q;
    assign out.excp_code = excp_code_q;

endmodule

//--- tests/fetch_backend_props.sv
`timescale 1ns/10ps

module fetch_backend_props (
    input logic                  clk,
    input logic                  rstn,
    input logic                  flush,
    input logic                  out_valid,
    input logic                  out_ready,
    input fetch_pkg::pc_t        out_pc,
    input fetch_pkg::inst_t      out_inst0,
    input fetch_pkg::inst_t      out_inst1,
    input logic                  out_excp_flag,
    input fetch_pkg::excp_code_t out_excp_code,
    input logic                  refetch_valid
);

    int assert_fails = 0; // read by the testbench at the end

    // decode must see a steady packet while it stalls
    out_stable_a: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready && !flush) |=>
            (out_valid && $stable({out_pc, out_inst0, out_inst1, out_excp_flag, out_excp_code})))
    else begin
        assert_fails++;
        $error("out packet changed or vanished while decode stalled");
    end

    refetch_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
        refetch_valid |=> !refetch_valid)
    else begin
        assert_fails++;
        $error("refetch_valid high on two cycles in a row");
    end

    flush_empty_a: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !out_valid)
    else begin
        assert_fails++;
        $error("out_valid still high after flush");
    end

endmodule

bind fetch_backend fetch_backend_props fetch_backend_props_inst (
    .clk           (clk),
    .rstn          (rstn),
    .flush         (flush),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_inst0     (out_inst0),
    .out_inst1     (out_inst1),
    .out_excp_flag (out_excp_flag),
    .out_excp_code (out_excp_code),
    .refetch_valid (refetch_valid)
);

//--- tests/fetch_backend_tb.sv
`timescale 1ns/10ps

module fetch_backend_tb;

    localparam int TIMEOUT = 200;
    localparam int PKT_W   = 104;
    localparam int M_IDLE  = 0;
    localparam int M_BLOCK = 1; // barrier seen, refetch not yet issued
    localparam int M_FETCH = 2;
    localparam fetch_pkg::inst_t IBAR_WORD = {fetch_pkg::IBAR_OP, 15'h0};

    logic clk = 1'b0;
    logic rstn, flush, in_valid, in_ready, in_excp_flag;
    logic ex_ibar_done, icache_idle, dcache_idle, refetch_valid;
    logic out_valid, out_ready, out_excp_flag;
    fetch_pkg::pc_t        in_pc, refetch_pc, out_pc;
    fetch_pkg::inst_t      in_inst0, in_inst1, out_inst0, out_inst1;
    fetch_pkg::excp_code_t in_excp_code, out_excp_code;

    integer           seed;
    int               ready_mode;  // 0 always ready, 1 random, 2 stalled
    int               model_mode;
    fetch_pkg::pc_t   model_rec;
    logic [PKT_W-1:0] exp_q[$];
    logic [PKT_W-1:0] exp_pkt;
    int               mismatches, other_errors, refetch_count, refetch_before, total;

    fetch_backend #(.FB_DEPTH(4)) fetch_backend_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        #2;
        if (ready_mode == 1) out_ready = ($random(seed) & 1) != 0;
        else out_ready = (ready_mode == 0);
    end

    // keep rule and recorded-address rule, applied per accepted input packet
    function automatic void model_packet(fetch_pkg::pc_t pc, fetch_pkg::inst_t i0,
                                         fetch_pkg::inst_t i1, logic flag,
                                         fetch_pkg::excp_code_t code);
        logic hit0;
        logic hit1;
        hit0 = i0[31:15] == fetch_pkg::IBAR_OP;
        hit1 = i1[31:15] == fetch_pkg::IBAR_OP;
        if (model_mode == M_IDLE || (model_mode == M_FETCH && pc == model_rec)) begin
            exp_q.push_back({pc, i0, i1, flag, code});
            model_mode = M_IDLE;
            if (!flag && (hit0 || hit1)) begin
                model_mode = M_BLOCK;
                model_rec  = hit0 ? pc + 32'd4 : pc + 32'd8;
            end
        end
    endfunction

    function automatic fetch_pkg::inst_t rand_inst();
        fetch_pkg::inst_t w;
        w = $random(seed);
        if (w[31:15] == fetch_pkg::IBAR_OP) w[31] = ~w[31];
        return w;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] actv);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expv, actv);
        mismatches++;
    endtask

    // decode side, a transfer happens at the next rising edge
    always @(negedge clk) begin
        if (refetch_valid) refetch_count++;
        if (rstn && !flush && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected packet at pc %h came out at %0t", out_pc, $time);
                other_errors++;
            end else begin
                exp_pkt = exp_q.pop_front();
                if (out_pc !== exp_pkt[103:72]) report_mismatch("out_pc", exp_pkt[103:72], out_pc);
                if (out_inst0 !== exp_pkt[71:40])
                    report_mismatch("out_inst0", exp_pkt[71:40], out_inst0);
                if (out_inst1 !== exp_pkt[39:8])
                    report_mismatch("out_inst1", exp_pkt[39:8], out_inst1);
                if (out_excp_flag !== exp_pkt[7])
                    report_mismatch("out_excp_flag", exp_pkt[7], out_excp_flag);
                if (out_excp_code !== exp_pkt[6:0])
                    report_mismatch("out_excp_code", exp_pkt[6:0], out_excp_code);
            end
        end
    end

    // called and returns 2 ns after a rising edge
    task automatic send_packet(fetch_pkg::pc_t pc, fetch_pkg::inst_t i0, fetch_pkg::inst_t i1,
                               logic flag, fetch_pkg::excp_code_t code);
        int waited;
        waited       = 0;
        in_valid     = 1'b1;
        in_pc        = pc;
        in_inst0     = i0;
        in_inst1     = i1;
        in_excp_flag = flag;
        in_excp_code = code;
        @(negedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("input packet at pc %h was never accepted", pc);
            other_errors++;
        end else begin
            model_packet(pc, i0, i1, flag, code);
        end
        @(posedge clk);
        #2 in_valid = 1'b0;
    endtask

    task automatic send_stream(fetch_pkg::pc_t start, int n, logic with_excp);
        fetch_pkg::pc_t pc;
        pc = start;
        repeat (n) begin
            send_packet(pc, rand_inst(), rand_inst(), with_excp && (($random(seed) & 7) == 0),
                        7'($random(seed)));
            pc = pc + 32'd8;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #2 waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected packets never came out", exp_q.size());
            other_errors++;
            exp_q.delete();
        end
    endtask

    // retire the barrier, then let both caches go idle
    task automatic release_barrier(fetch_pkg::pc_t exp_pc);
        int waited;
        int seen;
        waited = 0;
        seen   = refetch_count;
        @(posedge clk);
        #2 icache_idle = 1'b1; // idle caches before retirement
        dcache_idle = 1'b1;
        @(posedge clk);
        #2 ex_ibar_done = 1'b1;
        dcache_idle = 1'b0;
        @(posedge clk);
        #2 ex_ibar_done = 1'b0;
        repeat (2) @(posedge clk);
        #2 icache_idle = 1'b0; // one cache idle is not enough
        dcache_idle = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        if (refetch_count != seen) begin
            $display("refetch issued before retirement with both caches idle");
            other_errors++;
        end
        icache_idle = 1'b1;
        @(negedge clk);
        while (!refetch_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!refetch_valid) begin
            $display("no refetch request after the barrier was released");
            other_errors++;
        end else if (refetch_pc !== exp_pc) begin
            report_mismatch("refetch_pc", exp_pc, refetch_pc);
        end
        model_mode = M_FETCH;
        @(posedge clk);
        #2 icache_idle = 1'b0;
        dcache_idle = 1'b0;
    endtask

    task automatic do_flush();
        flush = 1'b1;
        exp_q.delete();
        model_mode = M_IDLE;
        @(posedge clk);
        #2 flush = 1'b0;
        if (out_valid) begin
            $display("out_valid still high after flush at %0t", $time);
            other_errors++;
        end
    endtask

    initial begin
        seed = 32'hed56;
        {rstn, flush, in_valid, in_excp_flag, ex_ibar_done, icache_idle, dcache_idle} = '0;
        {in_pc, in_inst0, in_inst1, in_excp_code} = '0;
        out_ready = 1'b0;
        {ready_mode, model_mode, mismatches, other_errors, refetch_count} = '0;
        model_rec = fetch_pkg::PC_RESET;
        repeat (10) begin
            @(negedge clk);
            if (in_ready || out_valid || refetch_valid) begin
                $display("output active during reset at %0t", $time);
                other_errors++;
            end
        end
        @(posedge clk);
        #2 rstn = 1'b1;

        // plain stream under random back-pressure
        ready_mode = 1;
        send_stream(32'h1c00_0000, 40, 1'b1);
        wait_drained();
        ready_mode = 0;

        // ibar in inst0, stale packets dropped until refetch
        send_packet(32'h1c00_1000, IBAR_WORD, rand_inst(), 1'b0, '0);
        send_stream(32'h1c00_1008, 2, 1'b0);
        wait_drained();
        release_barrier(32'h1c00_1004);
        send_stream(32'h1c00_1004, 3, 1'b0);
        wait_drained();

        // ibar only in inst1, mismatching pcs dropped in WAIT_FETCH
        send_packet(32'h1c00_2000, rand_inst(), IBAR_WORD, 1'b0, '0);
        send_stream(32'h1c00_2008, 2, 1'b0);
        wait_drained();
        release_barrier(32'h1c00_2008);
        send_stream(32'h1c00_2010, 2, 1'b0);
        send_stream(32'h1c00_2008, 3, 1'b0);
        wait_drained();

        // faulting packet is not scanned
        refetch_before = refetch_count;
        ex_ibar_done   = 1'b1; // would release a wrongly started wait
        icache_idle    = 1'b1;
        dcache_idle    = 1'b1;
        send_packet(32'h1c00_3000, IBAR_WORD, IBAR_WORD, 1'b1, 7'h08);
        send_stream(32'h1c00_3008, 3, 1'b0);
        wait_drained();
        ex_ibar_done = 1'b0;
        icache_idle  = 1'b0;
        dcache_idle  = 1'b0;
        if (refetch_count != refetch_before) begin
            $display("refetch issued for a packet with the exception flag");
            other_errors++;
        end

        // flush mid-stream, then during a barrier wait
        ready_mode = 2;
        send_stream(32'h1c00_4000, 3, 1'b0);
        do_flush();
        ready_mode = 0;
        send_stream(32'h1c00_4100, 3, 1'b0);
        wait_drained();
        send_packet(32'h1c00_5000, IBAR_WORD, rand_inst(), 1'b0, '0);
        send_stream(32'h1c00_5008, 2, 1'b0);
        wait_drained();
        @(posedge clk);
        #2 ex_ibar_done = 1'b1;
        @(posedge clk);
        #2 ex_ibar_done = 1'b0;
        refetch_before = refetch_count;
        do_flush();
        icache_idle = 1'b1;
        dcache_idle = 1'b1;
        send_stream(32'h1c00_6000, 3, 1'b0);
        wait_drained();
        if (refetch_count != refetch_before) begin
            $display("refetch issued after the barrier wait was flushed");
            other_errors++;
        end

        total = mismatches + other_errors
                + fetch_backend_inst.fetch_backend_props_inst.assert_fails;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures", mismatches,
                 other_errors, fetch_backend_inst.fetch_backend_props_inst.assert_fails);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
